//--- common/dram_pkg.sv
// shared types for the memory traffic path
package dram_pkg;

    // burst-addressed bus widths
    localparam int ADDR_W = 24;    // {row, bank, col} as one flat number
    localparam int DATA_W = 128;   // one burst
    localparam int TAG_W  = 16;

    // defaults the top level hands down
    localparam int DEFAULT_MAX_OUTSTANDING = 8;   // arbiter order FIFO depth
    localparam int DEFAULT_RESP_DEPTH      = 4;   // reader response FIFO depth

    typedef logic [ADDR_W-1:0] burst_addr_t;
    typedef logic [DATA_W-1:0] burst_data_t;

    // one command on the strobe/stall/ack bus
    typedef struct packed {
        burst_addr_t addr;
        logic        we;     // 1 = write, 0 = read
        burst_data_t data;   // ignored on reads
    } mem_cmd_t;

    // incoming sample stream
    typedef struct packed {
        burst_data_t data;
        logic        last;   // final beat of the load
    } write_beat_t;

    // read request word, echoed back with the data
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        burst_addr_t      addr;
    } read_req_t;

    typedef struct packed {
        burst_data_t data;
        read_req_t   req;
    } read_resp_t;

endpackage

//--- hdl/sample_writer.sv
`timescale 1ns/1ns
`default_nettype none

module sample_writer (
    input  wire                    clk_dram_ctrl,
    input  wire                    rst_dram_ctrl,
    input  dram_pkg::write_beat_t  i_wr_beat,
    input  wire                    i_wr_valid,
    input  wire                    i_grant,
    input  wire                    i_wr_done,
    output logic                   o_wr_ready,
    output logic                   o_req_valid,
    output dram_pkg::mem_cmd_t     o_cmd,
    output logic                   o_load_complete
);

    dram_pkg::burst_addr_t wr_addr;    // next burst to fill
    dram_pkg::burst_addr_t inflight;   // writes not yet acked
    logic armed;                       // one idle cycle out of reset
    logic last_sent;
    logic load_done;
    logic open;
    logic fire;

    // stream accepts beats only between reset and the last beat
    assign open        = armed && !last_sent;
    assign o_req_valid = i_wr_valid && open;
    assign o_wr_ready  = open && i_grant;
    assign fire        = o_req_valid && i_grant;

    assign o_cmd.addr = wr_addr;
    assign o_cmd.we   = 1'b1;
    assign o_cmd.data = i_wr_beat.data;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            armed     <= 1'b0;
            last_sent <= 1'b0;
            load_done <= 1'b0;
            wr_addr   <= '0;
            inflight  <= '0;
        end else begin
            armed <= 1'b1;
            if (fire) begin
                wr_addr <= wr_addr + 1'b1;
                if (i_wr_beat.last) begin
                    last_sent <= 1'b1;
                end
            end
            case ({fire, i_wr_done})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
            // no issues after the last beat, so this ack is the final one
            if (last_sent && i_wr_done && inflight == 1) begin
                load_done <= 1'b1;
            end
        end
    end

    assign o_load_complete = load_done;   // sticky until reset

endmodule

`default_nettype wire

//--- hdl/sample_reader.sv
`timescale 1ns/1ns
`default_nettype none

module sample_reader #(
    parameter int RESP_DEPTH = dram_pkg::DEFAULT_RESP_DEPTH
) (
    input  wire                    clk_dram_ctrl,
    input  wire                    rst_dram_ctrl,
    input  dram_pkg::read_req_t    i_rd_req,
    input  wire                    i_rd_req_valid,
    input  wire                    i_grant,
    input  wire                    i_rd_done,
    input  dram_pkg::burst_data_t  i_rd_data,
    input  wire                    i_rd_resp_ready,
    output logic                   o_rd_req_ready,
    output logic                   o_req_valid,
    output dram_pkg::mem_cmd_t     o_cmd,
    output dram_pkg::read_resp_t   o_rd_resp,
    output logic                   o_rd_resp_valid
);

    localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int CNT_W = $clog2(RESP_DEPTH + 1);

    // One ring holds both the in-flight request words and the finished
    // responses. A slot is claimed at issue, filled on read-done and
    // freed when the response is taken.
    dram_pkg::read_resp_t resp_mem [RESP_DEPTH];

    logic [PTR_W-1:0] alloc_ptr;   // next slot to claim
    logic [PTR_W-1:0] fill_ptr;    // oldest read in flight
    logic [PTR_W-1:0] rd_ptr;      // oldest finished response
    logic [CNT_W-1:0] used_cnt;    // claimed slots
    logic [CNT_W-1:0] ready_cnt;   // filled slots

    logic credit;
    logic issue;
    logic pop;

    // free slots already exclude reads in flight
    assign credit = (used_cnt != CNT_W'(RESP_DEPTH));

    assign o_req_valid    = i_rd_req_valid && credit;
    assign o_rd_req_ready = credit && i_grant;
    assign issue          = o_req_valid && i_grant;

    assign o_cmd.addr = i_rd_req.addr;
    assign o_cmd.we   = 1'b0;
    assign o_cmd.data = '0;

    assign o_rd_resp_valid = (ready_cnt != '0);
    assign o_rd_resp       = resp_mem[rd_ptr];
    assign pop             = o_rd_resp_valid && i_rd_resp_ready;

    always_ff @(posedge clk_dram_ctrl) begin
        if (issue) begin
            resp_mem[alloc_ptr].req <= i_rd_req;
        end
        if (i_rd_done) begin
            resp_mem[fill_ptr].data <= i_rd_data;   // pairs with oldest request
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            alloc_ptr <= '0;
            fill_ptr  <= '0;
            rd_ptr    <= '0;
            used_cnt  <= '0;
            ready_cnt <= '0;
        end else begin
            if (issue) begin
                alloc_ptr <= (alloc_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : alloc_ptr + 1'b1;
            end
            if (i_rd_done) begin
                fill_ptr <= (fill_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : fill_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({issue, pop})
                2'b10:   used_cnt <= used_cnt + 1'b1;
                2'b01:   used_cnt <= used_cnt - 1'b1;
                default: used_cnt <= used_cnt;
            endcase
            // valid the cycle after read-done
            case ({i_rd_done, pop})
                2'b10:   ready_cnt <= ready_cnt + 1'b1;
                2'b01:   ready_cnt <= ready_cnt - 1'b1;
                default: ready_cnt <= ready_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- arbiter/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter #(
    parameter int MAX_OUTSTANDING = dram_pkg::DEFAULT_MAX_OUTSTANDING
) (
    input  wire                    clk_dram_ctrl,
    input  wire                    rst_dram_ctrl,
    input  wire                    i_load_complete,

    // peers
    input  wire                    i_wr_valid,
    input  dram_pkg::mem_cmd_t     i_wr_cmd,
    input  wire                    i_rd_valid,
    input  dram_pkg::mem_cmd_t     i_rd_cmd,

    // memory bus
    input  wire                    i_mem_stall,
    input  wire                    i_mem_ack,
    input  dram_pkg::burst_data_t  i_mem_rdata,

    output logic                   o_wr_grant,
    output logic                   o_rd_grant,
    output dram_pkg::mem_cmd_t     o_mem_cmd,
    output logic                   o_mem_en,
    output logic                   o_wr_done,
    output logic                   o_rd_done,
    output dram_pkg::burst_data_t  o_rd_data
);

    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    // command register toward the controller
    dram_pkg::mem_cmd_t cmd_q;
    logic               en_q;

    // order FIFO, one type bit per command (1 = write)
    logic [MAX_OUTSTANDING-1:0] order_we;
    logic [PTR_W-1:0]           order_wr_ptr;
    logic [PTR_W-1:0]           order_rd_ptr;
    logic [CNT_W-1:0]           order_cnt;

    logic reg_free;
    logic order_full;
    logic can_issue;
    logic wr_take, rd_take, load;
    logic head_we;

    assign reg_free   = !en_q || !i_mem_stall;   // empty, or leaving this cycle
    assign order_full = (order_cnt == CNT_W'(MAX_OUTSTANDING));
    assign can_issue  = reg_free && !order_full;

    // writer first, reader only once the samples are in
    assign o_wr_grant = can_issue;
    assign o_rd_grant = can_issue && i_load_complete && !i_wr_valid;

    assign wr_take = i_wr_valid && o_wr_grant;
    assign rd_take = i_rd_valid && o_rd_grant;
    assign load    = wr_take || rd_take;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            en_q <= 1'b0;
        end else if (reg_free) begin
            en_q <= load;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (reg_free && load) begin
            cmd_q <= wr_take ? i_wr_cmd : i_rd_cmd;
        end
    end

    assign o_mem_cmd = cmd_q;
    assign o_mem_en  = en_q;

    // the type goes in as the command enters the register, so the
    // count covers the register as well as the commands awaiting ack
    always_ff @(posedge clk_dram_ctrl) begin
        if (load) begin
            order_we[order_wr_ptr] <= wr_take;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            order_wr_ptr <= '0;
            order_rd_ptr <= '0;
            order_cnt    <= '0;
        end else begin
            if (load) begin
                order_wr_ptr <= (order_wr_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ?
                                '0 : order_wr_ptr + 1'b1;
            end
            if (i_mem_ack) begin   // acks return in acceptance order
                order_rd_ptr <= (order_rd_ptr == PTR_W'(MAX_OUTSTANDING - 1)) ?
                                '0 : order_rd_ptr + 1'b1;
            end
            case ({load, i_mem_ack})
                2'b10:   order_cnt <= order_cnt + 1'b1;
                2'b01:   order_cnt <= order_cnt - 1'b1;
                default: order_cnt <= order_cnt;
            endcase
        end
    end

    // ack routing straight off the FIFO head
    assign head_we   = order_we[order_rd_ptr];
    assign o_wr_done = i_mem_ack && head_we;
    assign o_rd_done = i_mem_ack && !head_we;
    assign o_rd_data = i_mem_rdata;

endmodule

`default_nettype wire

//--- hdl/dram_traffic_top.sv
`timescale 1ns/1ns
`default_nettype none

module dram_traffic_top (
    input  wire                    clk_dram_ctrl,
    input  wire                    rst_dram_ctrl,

    // sample load stream
    input  dram_pkg::write_beat_t  i_wr_beat,
    input  wire                    i_wr_valid,
    output logic                   o_wr_ready,

    // tagged read requests
    input  dram_pkg::read_req_t    i_rd_req,
    input  wire                    i_rd_req_valid,
    output logic                   o_rd_req_ready,

    // read responses, in request order
    output dram_pkg::read_resp_t   o_rd_resp,
    output logic                   o_rd_resp_valid,
    input  wire                    i_rd_resp_ready,

    // memory controller side
    output dram_pkg::mem_cmd_t     o_mem_cmd,
    output logic                   o_mem_en,
    input  wire                    i_mem_stall,
    input  wire                    i_mem_ack,
    input  dram_pkg::burst_data_t  i_mem_rdata,

    output logic                   o_load_complete
);

    localparam int MAX_OUTSTANDING = dram_pkg::DEFAULT_MAX_OUTSTANDING;
    localparam int RESP_DEPTH      = dram_pkg::DEFAULT_RESP_DEPTH;

    dram_pkg::mem_cmd_t    wr_cmd;
    dram_pkg::mem_cmd_t    rd_cmd;
    dram_pkg::burst_data_t rd_data;
    logic wr_req_valid, rd_req_valid;
    logic wr_grant, rd_grant;
    logic wr_done, rd_done;

    sample_writer writer (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr_beat       (i_wr_beat),
        .i_wr_valid      (i_wr_valid),
        .i_grant         (wr_grant),
        .i_wr_done       (wr_done),
        .o_wr_ready      (o_wr_ready),
        .o_req_valid     (wr_req_valid),
        .o_cmd           (wr_cmd),
        .o_load_complete (o_load_complete)
    );

    sample_reader #(
        .RESP_DEPTH (RESP_DEPTH)
    ) reader (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_rd_req        (i_rd_req),
        .i_rd_req_valid  (i_rd_req_valid),
        .i_grant         (rd_grant),
        .i_rd_done       (rd_done),
        .i_rd_data       (rd_data),
        .i_rd_resp_ready (i_rd_resp_ready),
        .o_rd_req_ready  (o_rd_req_ready),
        .o_req_valid     (rd_req_valid),
        .o_cmd           (rd_cmd),
        .o_rd_resp       (o_rd_resp),
        .o_rd_resp_valid (o_rd_resp_valid)
    );

    mem_arbiter #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) arbiter (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_load_complete (o_load_complete),   // reads wait for the load
        .i_wr_valid      (wr_req_valid),
        .i_wr_cmd        (wr_cmd),
        .i_rd_valid      (rd_req_valid),
        .i_rd_cmd        (rd_cmd),
        .i_mem_stall     (i_mem_stall),
        .i_mem_ack       (i_mem_ack),
        .i_mem_rdata     (i_mem_rdata),
        .o_wr_grant      (wr_grant),
        .o_rd_grant      (rd_grant),
        .o_mem_cmd       (o_mem_cmd),
        .o_mem_en        (o_mem_en),
        .o_wr_done       (wr_done),
        .o_rd_done       (rd_done),
        .o_rd_data       (rd_data)
    );

endmodule

`default_nettype wire

//--- verif/dram_traffic_checker.sv
`timescale 1ns/1ns

module dram_traffic_checker (
    input wire                  clk_dram_ctrl,
    input wire                  rst_dram_ctrl,
    input dram_pkg::mem_cmd_t   i_mem_cmd,
    input wire                  i_mem_en,
    input wire                  i_mem_stall,
    input dram_pkg::read_resp_t i_rd_resp,
    input wire                  i_rd_resp_valid,
    input wire                  i_rd_resp_ready,
    input wire                  i_load_complete
);

    // stalled command holds until accepted
    mem_cmd_stable: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (i_mem_en && i_mem_stall) |=> (i_mem_en && $stable(i_mem_cmd)))
        else $error("memory command changed while stalled");

    resp_stable: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (i_rd_resp_valid && !i_rd_resp_ready) |=> (i_rd_resp_valid && $stable(i_rd_resp)))
        else $error("read response changed before it was taken");

    // sticky flag
    load_sticky: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        i_load_complete |=> i_load_complete)
        else $error("load complete fell outside reset");

endmodule

bind dram_traffic_top dram_traffic_checker protocol_check (
    .clk_dram_ctrl   (clk_dram_ctrl),
    .rst_dram_ctrl   (rst_dram_ctrl),
    .i_mem_cmd       (o_mem_cmd),
    .i_mem_en        (o_mem_en),
    .i_mem_stall     (i_mem_stall),
    .i_rd_resp       (o_rd_resp),
    .i_rd_resp_valid (o_rd_resp_valid),
    .i_rd_resp_ready (i_rd_resp_ready),
    .i_load_complete (o_load_complete)
);

//--- verif/tb_dram_traffic.sv
`timescale 1ns/1ns

module tb_dram_traffic;

    localparam int TIMEOUT    = 400;   // cycles allowed per wait
    localparam int NUM_BEATS  = 16;
    localparam int NUM_READS  = 12;
    localparam int RESP_DEPTH = dram_pkg::DEFAULT_RESP_DEPTH;

    logic                  clk_dram_ctrl;
    logic                  rst_dram_ctrl;
    dram_pkg::write_beat_t i_wr_beat;
    logic                  i_wr_valid;
    logic                  o_wr_ready;
    dram_pkg::read_req_t   i_rd_req;
    logic                  i_rd_req_valid;
    logic                  o_rd_req_ready;
    dram_pkg::read_resp_t  o_rd_resp;
    logic                  o_rd_resp_valid;
    logic                  i_rd_resp_ready;
    dram_pkg::mem_cmd_t    o_mem_cmd;
    logic                  o_mem_en;
    logic                  i_mem_stall;
    logic                  i_mem_ack;
    dram_pkg::burst_data_t i_mem_rdata;
    logic                  o_load_complete;

    integer seed;
    int     stall_pct;   // percent of cycles with stall high
    int     cycle_cnt;
    int     wr_accepts;
    int     rd_accepts;
    int     wr_acks;

    // memory model state
    int                    due_q[$];
    dram_pkg::burst_data_t rdata_q[$];
    logic                  pend_we_q[$];
    dram_pkg::burst_data_t mem_model [dram_pkg::burst_addr_t];

    dram_pkg::burst_data_t beats [NUM_BEATS];   // last loaded samples
    dram_pkg::read_req_t   exp_req_q[$];
    dram_pkg::read_resp_t  got_q[$];

    dram_traffic_top UUT (.*);

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #2 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    // command acceptance and response capture at the falling edge
    always @(negedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            due_q.delete();
            rdata_q.delete();
            pend_we_q.delete();
            wr_accepts = 0;
            rd_accepts = 0;
            wr_acks    = 0;
        end else begin
            if (o_mem_en && !i_mem_stall) begin
                if (o_mem_cmd.we) begin
                    mem_model[o_mem_cmd.addr] = o_mem_cmd.data;
                    wr_accepts++;
                    rdata_q.push_back('0);
                end else begin
                    rd_accepts++;
                    if (mem_model.exists(o_mem_cmd.addr)) begin
                        rdata_q.push_back(mem_model[o_mem_cmd.addr]);
                    end else begin
                        rdata_q.push_back('0);
                    end
                end
                due_q.push_back(cycle_cnt + 4);   // accepted on next edge, 3 cycles to ack
                pend_we_q.push_back(o_mem_cmd.we);
            end
            if (o_rd_resp_valid && i_rd_resp_ready) begin
                got_q.push_back(o_rd_resp);
            end
        end
    end

    // ack pipeline and random stall
    always @(posedge clk_dram_ctrl) begin
        cycle_cnt++;
        #1;
        if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
            i_mem_ack   = 1'b1;
            i_mem_rdata = rdata_q.pop_front();
            if (pend_we_q.pop_front()) begin
                wr_acks++;
            end
            void'(due_q.pop_front());
        end else begin
            i_mem_ack   = 1'b0;
            i_mem_rdata = '0;
        end
        i_mem_stall = ($unsigned($random(seed)) % 100) < stall_pct;
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic compare_burst(input string test, input dram_pkg::burst_data_t exp,
                                 input dram_pkg::burst_data_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", test, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_req(input string test, input dram_pkg::read_req_t exp,
                               input dram_pkg::read_req_t act);
        if (act !== exp) begin
            $display("FAIL %s expected tag %h addr %h actual tag %h addr %h",
                     test, exp.tag, exp.addr, act.tag, act.addr);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string test, input bit exp, input bit act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", test, exp, act);
            abort_run();
        end
    endtask

    function automatic dram_pkg::burst_data_t random_burst();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic dram_pkg::read_req_t random_req();
        dram_pkg::read_req_t req;
        logic [31:0]         r;
        r        = $random(seed);
        req.tag  = r[15:0];
        r        = $unsigned($random(seed)) % NUM_BEATS;   // only loaded bursts
        req.addr = r[23:0];
        return req;
    endfunction

    task automatic apply_reset();
        rst_dram_ctrl = 1'b1;
        repeat (8) @(posedge clk_dram_ctrl);
        #1;
        rst_dram_ctrl = 1'b0;
        got_q.delete();
        exp_req_q.delete();
    endtask

    task automatic send_beat(input dram_pkg::burst_data_t data, input logic last);
        int t;
        i_wr_beat  = '{data: data, last: last};
        i_wr_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk_dram_ctrl);
            t++;
            if (t > TIMEOUT) timed_out("o_wr_ready");
        end while (!o_wr_ready);
        @(posedge clk_dram_ctrl);
        #1;
        i_wr_valid = 1'b0;
    endtask

    task automatic send_req(input dram_pkg::read_req_t req);
        int t;
        i_rd_req       = req;
        i_rd_req_valid = 1'b1;
        t = 0;
        do begin
            @(negedge clk_dram_ctrl);
            t++;
            if (t > TIMEOUT) timed_out("o_rd_req_ready");
        end while (!o_rd_req_ready);
        @(posedge clk_dram_ctrl);
        #1;
        i_rd_req_valid = 1'b0;
        exp_req_q.push_back(req);
    endtask

    // responses must come back in request order with the loaded burst
    task automatic collect_responses(input string test, input int n);
        int                   t;
        dram_pkg::read_resp_t r;
        dram_pkg::read_req_t  e;
        t = 0;
        while (got_q.size() < n) begin
            @(negedge clk_dram_ctrl);
            t++;
            if (t > TIMEOUT) timed_out("read responses");
        end
        @(posedge clk_dram_ctrl);
        #1;
        for (int k = 0; k < n; k++) begin
            r = got_q.pop_front();
            e = exp_req_q.pop_front();
            compare_req(test, e, r.req);
            compare_burst(test, beats[e.addr[3:0]], r.data);
        end
    endtask

    task automatic test_after_reset();
        @(negedge clk_dram_ctrl);
        compare_flag("after_reset o_mem_en", 1'b0, o_mem_en);
        compare_flag("after_reset o_wr_ready", 1'b0, o_wr_ready);
        compare_flag("after_reset o_rd_resp_valid", 1'b0, o_rd_resp_valid);
        compare_flag("after_reset o_load_complete", 1'b0, o_load_complete);
        @(posedge clk_dram_ctrl);
        #1;
        i_rd_req       = '{tag: 16'h1234, addr: '0};
        i_rd_req_valid = 1'b1;
        repeat (20) begin
            @(negedge clk_dram_ctrl);
            compare_flag("after_reset o_rd_req_ready", 1'b0, o_rd_req_ready);
        end
        @(posedge clk_dram_ctrl);
        #1;
        i_rd_req_valid = 1'b0;
    endtask

    task automatic load_samples(input string test);
        int t;
        for (int k = 0; k < NUM_BEATS; k++) begin
            beats[k] = random_burst();
            send_beat(beats[k], k == NUM_BEATS - 1);
        end
        t = 0;
        while (!o_load_complete) begin
            @(negedge clk_dram_ctrl);
            t++;
            if (t > TIMEOUT) timed_out("o_load_complete");
        end
        compare_flag({test, " writes acked before load complete"}, 1'b1,
                     wr_acks == NUM_BEATS);
        for (int k = 0; k < NUM_BEATS; k++) begin
            if (!mem_model.exists(dram_pkg::burst_addr_t'(k))) begin
                $display("burst %0d was never written to memory", k);
                abort_run();
            end
            compare_burst({test, " stored burst"}, beats[k],
                          mem_model[dram_pkg::burst_addr_t'(k)]);
        end
        // stream stays closed after the last beat
        @(posedge clk_dram_ctrl);
        #1;
        i_wr_valid = 1'b1;
        repeat (10) begin
            @(negedge clk_dram_ctrl);
            compare_flag({test, " o_wr_ready after load"}, 1'b0, o_wr_ready);
        end
        @(posedge clk_dram_ctrl);
        #1;
        i_wr_valid = 1'b0;
    endtask

    task automatic run_reads(input string test, input int n);
        for (int k = 0; k < n; k++) begin
            send_req(random_req());
        end
        collect_responses(test, n);
    endtask

    task automatic test_backpressure();
        int                  accepted;
        int                  t;
        bit                  taken;
        bit                  refused;
        dram_pkg::read_req_t req;
        i_rd_resp_ready = 1'b0;
        accepted = 0;
        refused  = 1'b0;
        while (!refused && accepted < 2 * RESP_DEPTH) begin
            req            = random_req();
            i_rd_req       = req;
            i_rd_req_valid = 1'b1;
            t = 0;
            do begin
                @(negedge clk_dram_ctrl);
                t++;
                taken = o_rd_req_ready;
            end while (!taken && t < 40);   // a refusal is expected here
            @(posedge clk_dram_ctrl);
            #1;
            i_rd_req_valid = 1'b0;
            if (taken) begin
                accepted++;
                exp_req_q.push_back(req);
            end else begin
                refused = 1'b1;
            end
        end
        compare_flag("backpressure ready dropped", 1'b1, refused);
        compare_flag("backpressure accepted within depth", 1'b1, accepted <= RESP_DEPTH);
        compare_flag("backpressure response waiting", 1'b1, o_rd_resp_valid);
        i_rd_resp_ready = 1'b1;
        collect_responses("backpressure", accepted);
    endtask

    task automatic test_stall();
        stall_pct = 50;
        apply_reset();
        load_samples("stall");
        run_reads("stall", NUM_READS);
        compare_flag($sformatf("stall write accepts %0d", wr_accepts), 1'b1,
                     wr_accepts == NUM_BEATS);
        compare_flag($sformatf("stall read accepts %0d", rd_accepts), 1'b1,
                     rd_accepts == NUM_READS);
        stall_pct = 10;
    endtask

    initial begin
        seed            = 30982;
        stall_pct       = 10;
        cycle_cnt       = 0;
        wr_accepts      = 0;
        rd_accepts      = 0;
        wr_acks         = 0;
        rst_dram_ctrl   = 1'b1;
        i_wr_beat       = '0;
        i_wr_valid      = 1'b0;
        i_rd_req        = '0;
        i_rd_req_valid  = 1'b0;
        i_rd_resp_ready = 1'b1;
        i_mem_stall     = 1'b0;
        i_mem_ack       = 1'b0;
        i_mem_rdata     = '0;
        apply_reset();
        test_after_reset();
        load_samples("load");
        run_reads("reads", NUM_READS);
        test_backpressure();
        test_stall();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- files.f
common/dram_pkg.sv
hdl/sample_writer.sv
hdl/sample_reader.sv
arbiter/mem_arbiter.sv
hdl/dram_traffic_top.sv
verif/dram_traffic_checker.sv
verif/tb_dram_traffic.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dram_traffic -f files.f -o sim_dram_traffic &&
./obj_dir/sim_dram_traffic || exit 1
